//--- design/mem_consts.svh
// memory stage constants
// address map, cache geometry and datapath widths
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// datapath
`define MEM_XLEN 64
`define MEM_LINE_BITS 128

// cache geometry, 16 bytes per line
`define MEM_CACHE_LINES 16

// core-local interruptor window, 64 KiB
`define MEM_CLINT_BASE 64'h0000_0000_0200_0000
`define MEM_CLINT_MASK 64'hFFFF_FFFF_FFFF_0000

// register offsets inside the window
`define MEM_MTIMECMP_OFF 16'h4000
`define MEM_MTIME_OFF 16'hBFF8

`endif

//--- design/mem_op_pkg.sv
// load/store operation types
// opcode carries width in bits [1:0] and zero extension in bit 2
`default_nettype none

package mem_op_pkg;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } mem_op_e;

    // same order as the low opcode bits
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10,
        SIZE_D = 2'b11
    } mem_size_e;

endpackage

`default_nettype wire

//--- design/cache_pkg.sv
// data cache controller types
`default_nettype none

package cache_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FLUSH_SCAN,
        FLUSH_WB,
        RESPOND
    } cache_state_e;

endpackage

`default_nettype wire

//--- design/mem_align.sv
// load/store alignment
// places store bytes on their lanes and extends load data to 64 bits
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module mem_align (
    input  mem_op_pkg::mem_op_e   op_i,
    input  logic [2:0]            addr_lo_i,
    input  logic [`MEM_XLEN-1:0]  wdata_i,
    input  logic [`MEM_XLEN-1:0]  word_i,
    output logic [7:0]            wmask_o,
    output logic [`MEM_XLEN-1:0]  wdata_o,
    output logic [`MEM_XLEN-1:0]  rdata_o
);
    import mem_op_pkg::*;

    mem_size_e            size;
    logic                 zext;
    logic [5:0]           bit_off;
    logic [`MEM_XLEN-1:0] lane;
    logic [`MEM_XLEN-1:0] rshift;

    assign size    = mem_size_e'(op_i[1:0]);
    assign zext    = op_i[2];
    assign bit_off = {addr_lo_i, 3'b000};

    // trim store data to its size before moving it up
    always_comb begin
        case (size)
            SIZE_B: begin
                lane    = {56'b0, wdata_i[7:0]};
                wmask_o = 8'h01 << addr_lo_i;
            end
            SIZE_H: begin
                lane    = {48'b0, wdata_i[15:0]};
                wmask_o = 8'h03 << addr_lo_i;
            end
            SIZE_W: begin
                lane    = {32'b0, wdata_i[31:0]};
                wmask_o = 8'h0f << addr_lo_i;
            end
            default: begin
                lane    = wdata_i;
                wmask_o = 8'hff;
            end
        endcase
    end

    assign wdata_o = lane << bit_off;

    // addressed bytes down to bit 0
    assign rshift = word_i >> bit_off;

    always_comb begin
        case (size)
            SIZE_B: begin
                rdata_o = {{56{rshift[7] & ~zext}}, rshift[7:0]};
            end
            SIZE_H: begin
                rdata_o = {{48{rshift[15] & ~zext}}, rshift[15:0]};
            end
            SIZE_W: begin
                rdata_o = {{32{rshift[31] & ~zext}}, rshift[31:0]};
            end
            default: begin
                rdata_o = rshift;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/dcache.sv
// direct-mapped write-back, write-allocate data cache
// one 128-bit line per memory transfer, fence writes back and invalidates all
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module dcache (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_valid_i,
    input  logic                      cpu_write_i,
    input  logic                      cpu_fence_i,
    input  logic [`MEM_XLEN-1:0]      cpu_addr_i,
    input  logic [`MEM_XLEN-1:0]      cpu_wdata_i,
    input  logic [7:0]                cpu_wmask_i,
    output logic [`MEM_XLEN-1:0]      cpu_rdata_o,
    output logic                      cpu_ready_o,
    output logic                      mem_valid_o,
    output logic                      mem_write_o,
    output logic [`MEM_XLEN-1:0]      mem_addr_o,
    output logic [`MEM_LINE_BITS-1:0] mem_wdata_o,
    input  logic [`MEM_LINE_BITS-1:0] mem_rdata_i,
    input  logic                      mem_ready_i
);
    import cache_pkg::*;

    localparam int LINES    = `MEM_CACHE_LINES;
    localparam int OFF_BITS = $clog2(`MEM_LINE_BITS / 8);
    localparam int IDX_BITS = $clog2(LINES);
    localparam int TAG_BITS = `MEM_XLEN - IDX_BITS - OFF_BITS;

    logic [TAG_BITS-1:0]       tag_q   [LINES];
    logic [`MEM_LINE_BITS-1:0] data_q  [LINES];
    logic [LINES-1:0]          valid_q;
    logic [LINES-1:0]          dirty_q;

    cache_state_e         state_q;
    cache_state_e         state_d;
    logic [IDX_BITS-1:0]  scan_q;
    logic [IDX_BITS-1:0]  scan_d;
    logic [IDX_BITS-1:0]  idx;
    logic [IDX_BITS-1:0]  wb_idx;
    logic [TAG_BITS-1:0]  req_tag;
    logic [6:0]           half_lsb;
    logic [`MEM_XLEN-1:0] cur_word;
    logic [`MEM_XLEN-1:0] merged_word;
    logic                 hit;
    logic                 do_access;
    logic                 scan_last;

    assign idx      = cpu_addr_i[OFF_BITS +: IDX_BITS];
    assign req_tag  = cpu_addr_i[`MEM_XLEN-1 -: TAG_BITS];
    assign half_lsb = {cpu_addr_i[3], 6'b0};
    assign hit      = valid_q[idx] && (tag_q[idx] == req_tag);

    assign scan_last = (scan_q == IDX_BITS'(LINES - 1));

    // a hit in LOOKUP, or the retry after a refill
    assign do_access   = ((state_q == LOOKUP) && hit) || ((state_q == RESPOND) && !cpu_fence_i);
    assign cpu_ready_o = ((state_q == LOOKUP) && hit) || (state_q == RESPOND);

    assign cur_word    = data_q[idx][half_lsb +: `MEM_XLEN];
    assign cpu_rdata_o = cur_word;

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            merged_word[b*8 +: 8] = cpu_wmask_i[b] ? cpu_wdata_i[b*8 +: 8] : cur_word[b*8 +: 8];
        end
    end

    // memory port, victim line comes from the scan counter during a fence
    assign wb_idx      = (state_q == FLUSH_WB) ? scan_q : idx;
    assign mem_valid_o = (state_q == WRITEBACK) || (state_q == REFILL) || (state_q == FLUSH_WB);
    assign mem_write_o = (state_q == WRITEBACK) || (state_q == FLUSH_WB);
    assign mem_wdata_o = data_q[wb_idx];
    assign mem_addr_o  = mem_write_o ? {tag_q[wb_idx], wb_idx, {OFF_BITS{1'b0}}}
                                     : {req_tag, idx, {OFF_BITS{1'b0}}};

    always_comb begin
        state_d = state_q;
        scan_d  = scan_q;
        case (state_q)
            IDLE: begin
                if (cpu_valid_i && cpu_fence_i) begin
                    state_d = FLUSH_SCAN;
                    scan_d  = '0;
                end else if (cpu_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = IDLE;
                end else if (valid_q[idx] && dirty_q[idx]) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (mem_ready_i) begin
                    state_d = RESPOND;
                end
            end
            FLUSH_SCAN: begin
                if (valid_q[scan_q] && dirty_q[scan_q]) begin
                    state_d = FLUSH_WB;
                end else if (scan_last) begin
                    state_d = RESPOND;
                end else begin
                    scan_d = scan_q + 1'b1;
                end
            end
            FLUSH_WB: begin
                // back to the same line, now clean
                if (mem_ready_i) begin
                    state_d = FLUSH_SCAN;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            scan_q  <= '0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            scan_q  <= scan_d;
            if ((state_q == REFILL) && mem_ready_i) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= 1'b0;
            end
            if (do_access && cpu_write_i) begin
                dirty_q[idx] <= 1'b1;
            end
            if ((state_q == FLUSH_SCAN) && !(valid_q[scan_q] && dirty_q[scan_q])) begin
                valid_q[scan_q] <= 1'b0;
            end
            if ((state_q == FLUSH_WB) && mem_ready_i) begin
                dirty_q[scan_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == REFILL) && mem_ready_i) begin
            data_q[idx] <= mem_rdata_i;
            tag_q[idx]  <= req_tag;
        end else if (do_access && cpu_write_i) begin
            data_q[idx][half_lsb +: `MEM_XLEN] <= merged_word;
        end
    end

endmodule

`default_nettype wire

//--- design/clint_timer.sv
// core-local timer
// free-running mtime, writable mtimecmp, level interrupt on mtime >= mtimecmp
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module clint_timer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wen_i,
    input  logic                 sel_cmp_i,
    input  logic [`MEM_XLEN-1:0] wdata_i,
    output logic [`MEM_XLEN-1:0] rdata_o,
    output logic                 irq_o
);
    logic [`MEM_XLEN-1:0] mtime_q;
    logic [`MEM_XLEN-1:0] mtimecmp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // all ones keeps the interrupt quiet until software sets a deadline
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '1;
        end else if (wen_i) begin
            mtimecmp_q <= wdata_i;
        end
    end

    assign rdata_o = sel_cmp_i ? mtimecmp_q : mtime_q;
    assign irq_o   = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

//--- design/mem_stage.sv
// data memory stage of the core
// routes each request to the data cache or the CLINT timer, aligns data
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module mem_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req_valid_i,
    input  mem_op_pkg::mem_op_e       req_op_i,
    input  logic                      req_write_i,
    input  logic                      req_fence_i,
    input  logic [`MEM_XLEN-1:0]      req_addr_i,
    input  logic [`MEM_XLEN-1:0]      req_wdata_i,
    output logic                      req_ready_o,
    output logic [`MEM_XLEN-1:0]      rdata_o,
    output logic                      mem_valid_o,
    output logic                      mem_write_o,
    output logic [`MEM_XLEN-1:0]      mem_addr_o,
    output logic [`MEM_LINE_BITS-1:0] mem_wdata_o,
    input  logic [`MEM_LINE_BITS-1:0] mem_rdata_i,
    input  logic                      mem_ready_i,
    output logic                      timer_irq_o
);
    logic                 is_clint;
    logic [15:0]          clint_off;
    logic                 clint_valid;
    logic                 cpu_valid;
    logic                 cpu_ready;
    logic [`MEM_XLEN-1:0] cpu_rdata;
    logic [`MEM_XLEN-1:0] cpu_wdata;
    logic [7:0]           cpu_wmask;
    logic                 tmr_wen;
    logic                 tmr_sel_cmp;
    logic [`MEM_XLEN-1:0] tmr_rdata;
    logic [`MEM_XLEN-1:0] load_word;

    assign is_clint  = ((req_addr_i & `MEM_CLINT_MASK) == `MEM_CLINT_BASE);
    assign clint_off = req_addr_i[15:0];

    // fence always goes to the cache
    assign clint_valid = req_valid_i && !req_fence_i && is_clint;
    assign cpu_valid   = req_valid_i && (req_fence_i || !is_clint);

    // only mtimecmp is writable, everything but mtime reads mtimecmp
    assign tmr_sel_cmp = (clint_off != `MEM_MTIME_OFF);
    assign tmr_wen     = clint_valid && req_write_i && (clint_off == `MEM_MTIMECMP_OFF);

    // timer answers in the same cycle
    assign req_ready_o = clint_valid || (cpu_valid && cpu_ready);
    assign load_word   = is_clint ? tmr_rdata : cpu_rdata;

    mem_align i_align (
        .op_i      (req_op_i),
        .addr_lo_i (req_addr_i[2:0]),
        .wdata_i   (req_wdata_i),
        .word_i    (load_word),
        .wmask_o   (cpu_wmask),
        .wdata_o   (cpu_wdata),
        .rdata_o   (rdata_o)
    );

    dcache i_dcache (
        .clk         (clk),
        .rst         (rst),
        .cpu_valid_i (cpu_valid),
        .cpu_write_i (req_write_i),
        .cpu_fence_i (req_fence_i),
        .cpu_addr_i  (req_addr_i),
        .cpu_wdata_i (cpu_wdata),
        .cpu_wmask_i (cpu_wmask),
        .cpu_rdata_o (cpu_rdata),
        .cpu_ready_o (cpu_ready),
        .mem_valid_o (mem_valid_o),
        .mem_write_o (mem_write_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ready_i (mem_ready_i)
    );

    clint_timer i_timer (
        .clk       (clk),
        .rst       (rst),
        .wen_i     (tmr_wen),
        .sel_cmp_i (tmr_sel_cmp),
        .wdata_i   (cpu_wdata),
        .rdata_o   (tmr_rdata),
        .irq_o     (timer_irq_o)
    );

endmodule

`default_nettype wire

//--- sim/mem_stage_asserts.sv
// protocol checks for the data memory stage
// memory port stability, request handshake and alignment, reset state
`timescale 1ns/1ps
`default_nettype none

module mem_stage_asserts (
    input wire logic                   clk,
    input wire logic                   rst,
    input wire logic                   req_valid_i,
    input wire logic                   cache_valid_i,
    input wire logic                   cache_ready_i,
    input wire logic                   req_fence_i,
    input wire mem_op_pkg::mem_op_e    req_op_i,
    input wire logic [63:0]            req_addr_i,
    input wire logic                   mem_valid_i,
    input wire logic                   mem_write_i,
    input wire logic [63:0]            mem_addr_i,
    input wire logic [127:0]           mem_wdata_i,
    input wire logic                   mem_ready_i,
    input wire cache_pkg::cache_state_e cache_state_i
);
    import mem_op_pkg::*;
    import cache_pkg::*;

    mem_size_e size;
    logic      aligned;
    bit        stable_bad = 1'b0;
    bit        ready_bad = 1'b0;
    bit        align_bad = 1'b0;
    bit        reset_bad = 1'b0;
    logic      any_fail;

    assign size     = mem_size_e'(req_op_i[1:0]);
    assign any_fail = stable_bad | ready_bad | align_bad | reset_bad;

    always_comb begin
        case (size)
            SIZE_B:  aligned = 1'b1;
            SIZE_H:  aligned = (req_addr_i[0] == 1'b0);
            SIZE_W:  aligned = (req_addr_i[1:0] == 2'b00);
            default: aligned = (req_addr_i[2:0] == 3'b000);
        endcase
    end

    // memory request held until accepted
    a_mem_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_write_i)
            && $stable(mem_addr_i) && $stable(mem_wdata_i))
    else begin
        $error("memory request changed before it was accepted");
        stable_bad = 1'b1;
    end

    // the cache only completes a request that is still presented
    a_ready_valid: assert property (@(posedge clk) disable iff (rst)
        cache_ready_i |-> cache_valid_i)
    else begin
        $error("cache ready without a valid request");
        ready_bad = 1'b1;
    end

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        req_valid_i && !req_fence_i |-> aligned)
    else begin
        $error("misaligned request");
        align_bad = 1'b1;
    end

    a_reset: assert property (@(posedge clk)
        rst |=> !mem_valid_i && (cache_state_i == IDLE))
    else begin
        $error("memory port active or cache busy after a reset cycle");
        reset_bad = 1'b1;
    end

endmodule

bind mem_stage mem_stage_asserts i_asserts (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid_i),
    .cache_valid_i (cpu_valid),
    .cache_ready_i (cpu_ready),
    .req_fence_i   (req_fence_i),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .mem_valid_i   (mem_valid_o),
    .mem_write_i   (mem_write_o),
    .mem_addr_i    (mem_addr_o),
    .mem_wdata_i   (mem_wdata_o),
    .mem_ready_i   (mem_ready_i),
    .cache_state_i (i_dcache.state_q)
);

`default_nettype wire

//--- sim/tb_mem_stage.sv
// testbench for the data memory stage
// backing memory with random latency, byte shadow model and directed tests
`timescale 1ns/1ps
`default_nettype none
`include "mem_consts.svh"

module tb_mem_stage;
    import mem_op_pkg::*;

    localparam int PASS_REQS = 39;
    localparam int TOTAL_REQS = 2 * PASS_REQS + 3;
    localparam logic [63:0] MTIME_ADDR = `MEM_CLINT_BASE | 64'(`MEM_MTIME_OFF);
    localparam logic [63:0] CMP_ADDR = `MEM_CLINT_BASE | 64'(`MEM_MTIMECMP_OFF);

    logic                      clk;
    logic                      rst;
    logic                      req_valid_i;
    mem_op_e                   req_op_i;
    logic                      req_write_i;
    logic                      req_fence_i;
    logic [`MEM_XLEN-1:0]      req_addr_i;
    logic [`MEM_XLEN-1:0]      req_wdata_i;
    logic                      req_ready_o;
    logic [`MEM_XLEN-1:0]      rdata_o;
    logic                      mem_valid_o;
    logic                      mem_write_o;
    logic [`MEM_XLEN-1:0]      mem_addr_o;
    logic [`MEM_LINE_BITS-1:0] mem_wdata_o;
    logic [`MEM_LINE_BITS-1:0] mem_rdata_i;
    logic                      mem_ready_i;
    logic                      timer_irq_o;

    logic [7:0]  backing [0:4095];
    logic [7:0]  shadow [0:4095];
    bit          stored [0:4095];
    int          seed = 32'h3e837bba;
    int          checks = 0;
    int          test_errors = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          wait_cnt;
    int          mem_reads = 0;
    bit          bp_on = 1'b0;
    logic [63:0] last_wr_addr;
    logic [63:0] cycle_count;
    logic [63:0] cyc_done;
    logic [63:0] rd_val;

    mem_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        cycle_count = '0;
        forever begin
            #50;
            clk = 1'b1;
            cycle_count = cycle_count + 64'd1;
            #50;
            clk = 1'b0;
        end
    end

    initial begin
        repeat (TOTAL_REQS * 40) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", TOTAL_REQS * 40);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED @ %0t: %s, got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    function automatic logic [7:0] fill_byte(input int a);
        return 8'((a * 37) ^ (a >> 4));
    endfunction

    // sign or zero extension of the shadow bytes
    function automatic logic [63:0] expected_load(input mem_op_e op, input logic [63:0] addr);
        int          n;
        logic [63:0] v;
        n = 1 << op[1:0];
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i*8 +: 8] = shadow[addr[11:0] + 12'(i)];
        end
        if (!op[2] && n < 8 && v[n*8-1]) begin
            v = v | ({64{1'b1}} << (n * 8));
        end
        return v;
    endfunction

    task automatic serve_line();
        logic [11:0]  base;
        logic [127:0] line;
        base = {mem_addr_o[11:4], 4'b0};
        if (mem_write_o) begin
            for (int i = 0; i < 16; i++) begin
                line[i*8 +: 8] = shadow[base + 12'(i)];
                backing[base + 12'(i)] = mem_wdata_o[i*8 +: 8];
            end
            check(mem_wdata_o[63:0], line[63:0], "written line, low half");
            check(mem_wdata_o[127:64], line[127:64], "written line, high half");
            last_wr_addr = mem_addr_o;
        end else begin
            for (int i = 0; i < 16; i++) begin
                line[i*8 +: 8] = backing[base + 12'(i)];
            end
            mem_rdata_i = line;
            mem_reads++;
        end
    endtask

    // backing memory answers after 0 to 3 cycles under back-pressure
    initial begin
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        wait_cnt = -1;
        forever begin
            @(negedge clk);
            mem_ready_i = 1'b0;
            if (!rst && mem_valid_o) begin
                if (wait_cnt < 0) begin
                    wait_cnt = bp_on ? int'({$random(seed)} % 4) : 0;
                end
                if (wait_cnt == 0) begin
                    serve_line();
                    mem_ready_i = 1'b1;
                end
                wait_cnt--;
            end
        end
    end

    // starts on a falling edge and returns on the one after completion
    task automatic do_request(input mem_op_e op, input logic wr, input logic fence,
                              input logic [63:0] addr, input logic [63:0] wdata);
        req_op_i = op;
        req_write_i = wr;
        req_fence_i = fence;
        req_addr_i = addr;
        req_wdata_i = wdata;
        req_valid_i = 1'b1;
        #1;
        while (!req_ready_o) begin
            @(negedge clk);
            #1;
        end
        rd_val = rdata_o;
        cyc_done = cycle_count;
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic store(input mem_op_e op, input logic [63:0] addr, input logic [63:0] wdata);
        int n;
        n = 1 << op[1:0];
        do_request(op, 1'b1, 1'b0, addr, wdata);
        for (int i = 0; i < n; i++) begin
            shadow[addr[11:0] + 12'(i)] = wdata[i*8 +: 8];
            stored[addr[11:0] + 12'(i)] = 1'b1;
        end
    endtask

    task automatic load_check(input mem_op_e op, input logic [63:0] addr, input string what);
        do_request(op, 1'b0, 1'b0, addr, '0);
        check(rd_val, expected_load(op, addr), what);
    endtask

    task automatic store_load_all_ops();
        mem_op_e     op;
        int          n;
        logic [63:0] addr;
        for (int k = 0; k < 7; k++) begin
            op = mem_op_e'(k[2:0]);
            n = 1 << op[1:0];
            addr = 64'h40 + 64'(k * 32);
            store(op, addr, {$random(seed), $random(seed)});
            load_check(op, addr, "load after store");
            addr = addr + 64'(16 - n);
            store(op, addr, {$random(seed), $random(seed)});
            load_check(op, addr, "load after store, upper lane");
        end
    endtask

    task automatic narrow_store_masking();
        store(LD, 64'h300, {$random(seed), $random(seed)});
        store(LB, 64'h301, {$random(seed), $random(seed)});
        store(LH, 64'h304, {$random(seed), $random(seed)});
        store(LB, 64'h307, {$random(seed), $random(seed)});
        load_check(LD, 64'h300, "doubleword after narrow stores");
    endtask

    // 0x520 and 0x920 share line index 2
    task automatic dirty_line_eviction();
        store(LD, 64'h520, {$random(seed), $random(seed)});
        last_wr_addr = '1;
        store(LD, 64'h920, {$random(seed), $random(seed)});
        check(last_wr_addr, 64'h520, "eviction write address");
        load_check(LD, 64'h520, "load of evicted line");
        load_check(LD, 64'h920, "load of conflicting line");
    endtask

    // 0x920 is still cached when the fence starts
    task automatic fence_flush();
        int bad;
        int r0;
        bad = 0;
        do_request(LD, 1'b0, 1'b1, 64'h0, '0);
        for (int a = 0; a < 4096; a++) begin
            if (stored[a] && backing[a] !== shadow[a]) begin
                bad++;
            end
        end
        check(64'(bad), 64'd0, "bytes differing from shadow after fence");
        r0 = mem_reads;
        load_check(LD, 64'h920, "load after fence");
        check(64'(mem_reads - r0), 64'd1, "line reads after fence");
    endtask

    task automatic timer_compare();
        logic [63:0] t;
        logic [63:0] c0;
        do_request(LD, 1'b0, 1'b0, MTIME_ADDR, '0);
        t = rd_val;
        c0 = cyc_done;
        do_request(LD, 1'b1, 1'b0, CMP_ADDR, t + 64'd20);
        #1;
        while (!timer_irq_o) begin
            @(negedge clk);
            #1;
        end
        check(cycle_count - c0, 64'd20, "cycles until timer interrupt");
        @(negedge clk);
        do_request(LD, 1'b0, 1'b0, CMP_ADDR, '0);
        check(rd_val, t + 64'd20, "mtimecmp read back");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        rst = 1'b1;
        req_valid_i = 1'b0;
        req_op_i = LD;
        req_write_i = 1'b0;
        req_fence_i = 1'b0;
        req_addr_i = '0;
        req_wdata_i = '0;
        for (int a = 0; a < 4096; a++) begin
            backing[a] = fill_byte(a);
            shadow[a] = fill_byte(a);
            stored[a] = 1'b0;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        store_load_all_ops();
        finish_test("store and load of every opcode");
        narrow_store_masking();
        finish_test("byte masking");
        dirty_line_eviction();
        finish_test("dirty line eviction");
        fence_flush();
        finish_test("fence flush");
        timer_compare();
        finish_test("timer compare");
        bp_on = 1'b1;
        store_load_all_ops();
        narrow_store_masking();
        dirty_line_eviction();
        fence_flush();
        finish_test("back-pressure");
        if (i_dut.i_asserts.any_fail) begin
            $display("a protocol assertion on the DUT failed");
            errors++;
        end
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/mem_op_pkg.sv
design/cache_pkg.sv
design/mem_align.sv
design/dcache.sv
design/clint_timer.sv
design/mem_stage.sv
sim/mem_stage_asserts.sv
sim/tb_mem_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sim.f --top-module tb_mem_stage -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"$OBJ/Vtb_mem_stage" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx ">>> PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
